// ==== hwcnn_load.f ====
+incdir+source
source/hwcnn_cmd_pkg.sv
source/hwcnn_buf_pkg.sv
source/load_control.sv
source/fifo_fetch.sv
source/ddr_mux.sv
source/bias_buffer.sv
source/weight_buffer.sv
source/hwcnn_load_top.sv
tests/hwcnn_load_properties.sv
tests/hwcnn_load_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the parameter-load testbench with Verilator

LOG=sim.log
BUILD=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module hwcnn_load_tb \
	-f hwcnn_load.f -Mdir "$BUILD" -o hwcnn_load_sim
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

"$BUILD"/hwcnn_load_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tests/hwcnn_load_tb.sv ====
`timescale 1ns/1ps

`include "hwcnn_defines.svh"

module hwcnn_load_tb;

	localparam int CLK_PERIOD = 20;
	localparam int DDR_BEATS = 64;
	localparam int BEAT_BYTES = `HW_DDR_DATA_LEN / 8;
	localparam int BB_DEPTH = 1 << `HW_ADDR_LEN_BB;
	localparam int WB_DEPTH = 1 << `HW_ADDR_LEN_WB;
	localparam int TOTAL_WORDS = 6 + 10 + 12 + 4 + 5; // Words loaded over all tests
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 300;

	logic                         clk;
	logic                         rst;
	hwcnn_cmd_pkg::inst_t         instruct;
	logic                         inst_empty;
	logic                         inst_req;
	logic                         ddr_conf;
	hwcnn_cmd_pkg::ddr_cmd_t      ddr_cmd;
	logic                         ddr_fifo_empty;
	logic                         ddr_fifo_req;
	logic [`HW_DDR_DATA_LEN-1:0]  ddr_fifo_data;
	logic                         busy;
	logic                         bias_rd_en;
	hwcnn_buf_pkg::bias_addr_t    bias_rd_addr;
	logic [`HW_SHIFT_LEN-1:0]     bias_shift;
	hwcnn_buf_pkg::bias_out_t     bias_out;
	logic                         bias_valid;
	logic                         weight_rd_en;
	hwcnn_buf_pkg::weight_addr_t  weight_rd_addr;
	hwcnn_buf_pkg::weight_word_t  weight_out;
	logic                         weight_valid;

	logic [31:0]                  rng_state = 32'd6301;
	logic [`HW_DDR_DATA_LEN-1:0]  ddr_mem [DDR_BEATS];
	logic [`HW_DDR_DATA_LEN-1:0]  bias_model [BB_DEPTH];
	logic [`HW_DDR_DATA_LEN-1:0]  weight_model [WB_DEPTH];
	bit                           bias_loaded [BB_DEPTH];
	bit                           weight_loaded [WB_DEPTH];
	hwcnn_cmd_pkg::inst_t         inst_q [$];
	logic [`HW_DDR_DATA_LEN-1:0]  beat_q [$];
	hwcnn_cmd_pkg::ddr_cmd_t      cmd_log [$];
	logic [`HW_DDR_DATA_LEN-1:0]  last_pop = '0;
	logic                         gap_mode = 1'b0; // Random empty gaps on the DDR FIFO
	int                           pop_count = 0;
	int                           errors = 0;
	int                           test_errors = 0;
	int                           checks = 0;

	hwcnn_load_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	task automatic expect_true(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("Error at %0t ns: %s", $time, msg);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Instruction FIFO and DDR models
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (!rst && inst_req && inst_q.size() != 0) begin
			inst_q.delete(0);
		end
		if (!rst && ddr_conf) begin
			cmd_log.push_back(ddr_cmd);
			for (int k = 0; k < int'(ddr_cmd.len) / BEAT_BYTES; k++) begin
				beat_q.push_back(ddr_mem[(int'(ddr_cmd.ddr_addr) / BEAT_BYTES + k) % DDR_BEATS]);
			end
		end
		if (!rst && ddr_fifo_req) begin
			expect_true(beat_q.size() != 0, "DDR FIFO was popped while it held no beat");
			if (beat_q.size() != 0) begin
				last_pop = beat_q.pop_front();
			end
			pop_count++;
		end
	end

	always @(negedge clk) begin
		inst_empty <= (inst_q.size() == 0);
		if (inst_q.size() != 0) begin
			instruct <= inst_q[0]; // Show-ahead head
		end
		ddr_fifo_data <= last_pop;
		ddr_fifo_empty <= (beat_q.size() == 0) || (gap_mode && (next_random() % 3 == 0));
	end

	function automatic hwcnn_cmd_pkg::inst_t make_inst(input hwcnn_cmd_pkg::opcode_t op,
		input int beat, input int count, input int buf_addr);
		hwcnn_cmd_pkg::inst_t inst;
		inst.op = op;
		inst.ddr_addr = 32'(beat * BEAT_BYTES);
		inst.count = 24'(count);
		inst.buf_addr = 8'(buf_addr);
		return inst;
	endfunction

	// Expected buffer contents after a load
	function automatic void record_load(input hwcnn_cmd_pkg::inst_t inst);
		int src;
		int dst;
		for (int k = 0; k < int'(inst.count); k++) begin
			src = (int'(inst.ddr_addr) / BEAT_BYTES + k) % DDR_BEATS;
			dst = int'(inst.buf_addr) + k;
			if (inst.op == hwcnn_cmd_pkg::OP_LOAD_BIAS) begin
				bias_model[dst % BB_DEPTH] = ddr_mem[src];
				bias_loaded[dst % BB_DEPTH] = 1'b1;
			end else if (inst.op == hwcnn_cmd_pkg::OP_LOAD_WEIGHT) begin
				weight_model[dst % WB_DEPTH] = ddr_mem[src];
				weight_loaded[dst % WB_DEPTH] = 1'b1;
			end
		end
	endfunction

	function automatic hwcnn_buf_pkg::bias_out_t expected_bias(
		input logic [`HW_DDR_DATA_LEN-1:0] word, input int shift);
		hwcnn_buf_pkg::bias_out_t res;
		logic [`HW_BIAS_LEN-1:0] raw;
		logic [`HW_COM_DATALEN-1:0] wide;
		for (int i = 0; i < `HW_BIAS_LANES; i++) begin
			raw = word[32 * i +: `HW_BIAS_LEN]; // Low 20 bits of each 32-bit slot
			wide = {{(`HW_COM_DATALEN - `HW_BIAS_LEN){raw[`HW_BIAS_LEN-1]}}, raw};
			res[i] = wide << shift;
		end
		return res;
	endfunction

	task automatic wait_until_done(input int max_cycles);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while ((inst_q.size() != 0 || busy) && cycles < max_cycles);
		expect_true(inst_q.size() == 0 && !busy,
			$sformatf("load sequence did not finish within %0d cycles", max_cycles));
	endtask

	task automatic check_cmd(input int idx, input hwcnn_cmd_pkg::inst_t inst);
		expect_true(cmd_log.size() > idx && cmd_log[idx].ddr_addr == inst.ddr_addr &&
			cmd_log[idx].len == 24'(int'(inst.count) * BEAT_BYTES),
			$sformatf("DDR command %0d wrong, %0d commands logged", idx, cmd_log.size()));
	endtask

	task automatic read_bias(input int addr, input int shift);
		@(negedge clk);
		bias_rd_en = 1'b1;
		bias_rd_addr = 7'(addr);
		bias_shift = 5'(shift);
		@(negedge clk);
		bias_rd_en = 1'b0;
		expect_true(bias_valid && bias_out == expected_bias(bias_model[addr], shift),
			$sformatf("bias word %0d shift %0d read %h", addr, shift, bias_out));
	endtask

	task automatic read_weight(input int addr);
		@(negedge clk);
		weight_rd_en = 1'b1;
		weight_rd_addr = 8'(addr);
		@(negedge clk);
		weight_rd_en = 1'b0;
		expect_true(weight_valid && weight_out == weight_model[addr],
			$sformatf("weight word %0d read %h", addr, weight_out));
	endtask

	task automatic verify_bias_all(input int shift);
		for (int a = 0; a < BB_DEPTH; a++) begin
			if (bias_loaded[a]) read_bias(a, shift);
		end
	endtask

	task automatic verify_weight_all();
		for (int a = 0; a < WB_DEPTH; a++) begin
			if (weight_loaded[a]) read_weight(a);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic test_reset();
		expect_true(!inst_req && !ddr_conf && !ddr_fifo_req && !busy && !bias_valid &&
			!weight_valid && uut.bias_idle && uut.weight_idle, "outputs not at rest after reset");
		repeat (5) begin
			@(negedge clk);
			expect_true(!inst_req, "inst_req raised while the instruction FIFO was empty");
		end
	endtask

	task automatic test_bias_load();
		hwcnn_cmd_pkg::inst_t inst;
		int shifts [4] = '{0, 3, 12, 31};
		inst = make_inst(hwcnn_cmd_pkg::OP_LOAD_BIAS, 4, 6, 10);
		cmd_log.delete();
		@(posedge clk);
		inst_q.push_back(inst);
		wait_until_done(6 * 40);
		record_load(inst);
		expect_true(cmd_log.size() == 1, "bias load did not issue exactly one DDR command");
		check_cmd(0, inst);
		foreach (shifts[i]) verify_bias_all(shifts[i]);
	endtask

	task automatic test_weight_load();
		hwcnn_cmd_pkg::inst_t inst;
		inst = make_inst(hwcnn_cmd_pkg::OP_LOAD_WEIGHT, 20, 10, 250); // Wraps past 255
		cmd_log.delete();
		@(posedge clk);
		inst_q.push_back(inst);
		wait_until_done(10 * 40);
		record_load(inst);
		check_cmd(0, inst);
		verify_weight_all();
	endtask

	task automatic test_backpressure();
		hwcnn_cmd_pkg::inst_t inst;
		inst = make_inst(hwcnn_cmd_pkg::OP_LOAD_WEIGHT, 20, 12, 100);
		pop_count = 0;
		gap_mode = 1'b1;
		@(posedge clk);
		inst_q.push_back(inst);
		wait_until_done(12 * 40);
		gap_mode = 1'b0;
		expect_true(pop_count == 12 && beat_q.size() == 0,
			$sformatf("busy fell after %0d of 12 words", pop_count));
		record_load(inst);
		verify_weight_all();
	endtask

	task automatic test_back_to_back();
		hwcnn_cmd_pkg::inst_t bias_inst;
		hwcnn_cmd_pkg::inst_t nop_inst;
		hwcnn_cmd_pkg::inst_t weight_inst;
		bias_inst = make_inst(hwcnn_cmd_pkg::OP_LOAD_BIAS, 40, 4, 60);
		nop_inst = make_inst(hwcnn_cmd_pkg::OP_NOP, 0, 0, 0);
		weight_inst = make_inst(hwcnn_cmd_pkg::OP_LOAD_WEIGHT, 44, 5, 30);
		cmd_log.delete();
		@(posedge clk);
		inst_q.push_back(bias_inst);
		inst_q.push_back(nop_inst);
		inst_q.push_back(weight_inst);
		wait_until_done(9 * 40 + 20);
		expect_true(cmd_log.size() == 2, "expected two DDR commands for bias, NOP, weight");
		check_cmd(0, bias_inst);
		check_cmd(1, weight_inst);
		record_load(bias_inst);
		record_load(weight_inst);
		verify_bias_all(5);
		verify_weight_all();
	endtask

	initial begin
		rst = 1'b1;
		instruct = '0;
		inst_empty = 1'b1;
		ddr_fifo_empty = 1'b1;
		ddr_fifo_data = '0;
		bias_rd_en = 1'b0;
		bias_rd_addr = '0;
		bias_shift = '0;
		weight_rd_en = 1'b0;
		weight_rd_addr = '0;
		for (int b = 0; b < DDR_BEATS; b++) begin
			for (int w = 0; w < `HW_DDR_DATA_LEN / 32; w++) begin
				ddr_mem[b][32 * w +: 32] = next_random();
			end
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;
		test_reset();
		finish_test("reset");
		test_bias_load();
		finish_test("bias_load");
		test_weight_load();
		finish_test("weight_load");
		test_backpressure();
		finish_test("backpressure");
		test_back_to_back();
		finish_test("back_to_back");
		$display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== tests/hwcnn_load_properties.sv ====
`timescale 1ns/1ps

module hwcnn_load_properties (
	input logic clk,
	input logic rst,
	input logic pulse, // One-cycle strobe
	input logic req,
	input logic blocked // No req while high
);

	pulse_one_cycle: assert property (@(posedge clk) disable iff (rst) pulse |=> !pulse)
		else $error("strobe held high for more than one cycle");

	req_not_blocked: assert property (@(posedge clk) disable iff (rst) !(req && blocked))
		else $error("request raised while blocked");

endmodule

////////////////////////////////////////////////////////////
// Attachment to the fetch controllers, the sequencer and the DDR port
////////////////////////////////////////////////////////////
bind fifo_fetch hwcnn_load_properties fetch_props (.clk(clk), .rst(rst),
	.pulse(ddr_conf), .req(buf_wea), .blocked(idle)); // No write once back at rest

// Owner idle while busy only at launch and at the end of a load
bind load_control hwcnn_load_properties ctrl_props (.clk(clk), .rst(rst),
	.pulse(busy && owner_idle), .req(bias_conf || weight_conf), .blocked(!owner_idle));

bind hwcnn_load_top hwcnn_load_properties ddr_props (.clk(clk), .rst(rst),
	.pulse(ddr_conf), .req(ddr_fifo_req), .blocked(ddr_fifo_empty));

// ==== source/hwcnn_load_top.sv ====
`timescale 1ns/1ps

`include "hwcnn_defines.svh"

module hwcnn_load_top (
	input  logic                          clk,
	input  logic                          rst,
	input  hwcnn_cmd_pkg::inst_t          instruct,
	input  logic                          inst_empty,
	output logic                          inst_req,
	output logic                          ddr_conf,
	output hwcnn_cmd_pkg::ddr_cmd_t       ddr_cmd,
	input  logic                          ddr_fifo_empty,
	output logic                          ddr_fifo_req,
	input  logic [`HW_DDR_DATA_LEN-1:0]   ddr_fifo_data,
	output logic                          busy,
	input  logic                          bias_rd_en,
	input  hwcnn_buf_pkg::bias_addr_t     bias_rd_addr,
	input  logic [`HW_SHIFT_LEN-1:0]      bias_shift,
	output hwcnn_buf_pkg::bias_out_t      bias_out,
	output logic                          bias_valid,
	input  logic                          weight_rd_en,
	input  hwcnn_buf_pkg::weight_addr_t   weight_rd_addr,
	output hwcnn_buf_pkg::weight_word_t   weight_out,
	output logic                          weight_valid
);

	hwcnn_cmd_pkg::fetch_conf_t   fetch_conf;
	hwcnn_cmd_pkg::src_t          sel;
	logic                         bias_conf, weight_conf;
	logic                         bias_idle, weight_idle;
	logic                         bias_ddr_conf, weight_ddr_conf;
	hwcnn_cmd_pkg::ddr_cmd_t      bias_ddr_cmd, weight_ddr_cmd;
	logic                         bias_fifo_empty, weight_fifo_empty;
	logic                         bias_fifo_req, weight_fifo_req;
	logic                         bb_wea, wb_wea;
	hwcnn_buf_pkg::bias_addr_t    bb_addr;
	hwcnn_buf_pkg::weight_addr_t  wb_addr;
	hwcnn_buf_pkg::bias_word_t    bb_data;
	hwcnn_buf_pkg::weight_word_t  wb_data;

	load_control ctrl (.clk(clk), .rst(rst), .instruct(instruct), .inst_empty(inst_empty),
		.inst_req(inst_req), .bias_conf(bias_conf), .weight_conf(weight_conf),
		.conf(fetch_conf), .sel(sel), .bias_idle(bias_idle), .weight_idle(weight_idle),
		.busy(busy));

	// Beat data goes to both fetchers, only the selected one pops
	fifo_fetch #(.payload_t(hwcnn_buf_pkg::bias_word_t), .ADDR_LEN(`HW_ADDR_LEN_BB)) bfc (
		.clk(clk), .rst(rst), .conf(bias_conf), .conf_data(fetch_conf),
		.ddr_conf(bias_ddr_conf), .ddr_cmd(bias_ddr_cmd), .ddr_fifo_empty(bias_fifo_empty),
		.ddr_fifo_req(bias_fifo_req), .ddr_fifo_data(ddr_fifo_data),
		.buf_wea(bb_wea), .buf_addr(bb_addr), .buf_data(bb_data), .idle(bias_idle));

	fifo_fetch #(.payload_t(hwcnn_buf_pkg::weight_word_t), .ADDR_LEN(`HW_ADDR_LEN_WB)) wfc (
		.clk(clk), .rst(rst), .conf(weight_conf), .conf_data(fetch_conf),
		.ddr_conf(weight_ddr_conf), .ddr_cmd(weight_ddr_cmd),
		.ddr_fifo_empty(weight_fifo_empty), .ddr_fifo_req(weight_fifo_req),
		.ddr_fifo_data(ddr_fifo_data),
		.buf_wea(wb_wea), .buf_addr(wb_addr), .buf_data(wb_data), .idle(weight_idle));

	ddr_mux mddr (.sel(sel), .ddr_conf(ddr_conf), .ddr_cmd(ddr_cmd),
		.ddr_fifo_empty(ddr_fifo_empty), .ddr_fifo_req(ddr_fifo_req),
		.bias_ddr_conf(bias_ddr_conf), .bias_ddr_cmd(bias_ddr_cmd),
		.bias_ddr_fifo_empty(bias_fifo_empty), .bias_ddr_fifo_req(bias_fifo_req),
		.weight_ddr_conf(weight_ddr_conf), .weight_ddr_cmd(weight_ddr_cmd),
		.weight_ddr_fifo_empty(weight_fifo_empty), .weight_ddr_fifo_req(weight_fifo_req));

	bias_buffer bb (.clk(clk), .rst(rst), .wea(bb_wea), .wr_addr(bb_addr), .wr_data(bb_data),
		.rd_en(bias_rd_en), .rd_addr(bias_rd_addr), .bias_shift(bias_shift),
		.bias_out(bias_out), .bias_valid(bias_valid));

	weight_buffer wb (.clk(clk), .rst(rst), .wea(wb_wea), .wr_addr(wb_addr),
		.wr_data(wb_data), .rd_en(weight_rd_en), .rd_addr(weight_rd_addr),
		.weight_out(weight_out), .weight_valid(weight_valid));

endmodule

// ==== source/weight_buffer.sv ====
`timescale 1ns/1ps

`include "hwcnn_defines.svh"

module weight_buffer (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wea,
	input  hwcnn_buf_pkg::weight_addr_t  wr_addr,
	input  hwcnn_buf_pkg::weight_word_t  wr_data,
	input  logic                         rd_en,
	input  hwcnn_buf_pkg::weight_addr_t  rd_addr,
	output hwcnn_buf_pkg::weight_word_t  weight_out,
	output logic                         weight_valid
);

	localparam int DEPTH = 1 << `HW_ADDR_LEN_WB;

	hwcnn_buf_pkg::weight_word_t mem [DEPTH];

	////////////////////////////////////////////////////////////
	// One write port, one registered read port
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wea) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			weight_out <= mem[rd_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			weight_valid <= 1'b0;
		end else begin
			weight_valid <= rd_en; // Word lands with valid
		end
	end

endmodule

// ==== source/bias_buffer.sv ====
`timescale 1ns/1ps

`include "hwcnn_defines.svh"

module bias_buffer (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wea,
	input  hwcnn_buf_pkg::bias_addr_t  wr_addr,
	input  hwcnn_buf_pkg::bias_word_t  wr_data,
	input  logic                       rd_en,
	input  hwcnn_buf_pkg::bias_addr_t  rd_addr,
	input  logic [`HW_SHIFT_LEN-1:0]   bias_shift,
	output hwcnn_buf_pkg::bias_out_t   bias_out,
	output logic                       bias_valid
);

	localparam int DEPTH = 1 << `HW_ADDR_LEN_BB;
	localparam int EXT = `HW_COM_DATALEN - `HW_BIAS_LEN;

	hwcnn_buf_pkg::bias_word_t mem [DEPTH];
	hwcnn_buf_pkg::bias_word_t rd_word;
	hwcnn_buf_pkg::bias_out_t  shifted;

	assign rd_word = mem[rd_addr];

	// Sign extend each lane, then shift and keep the low bits
	always_comb begin
		for (int i = 0; i < `HW_BIAS_LANES; i++) begin
			shifted[i] = {{EXT{rd_word[i].bias[`HW_BIAS_LEN-1]}}, rd_word[i].bias}
				<< bias_shift;
		end
	end

	always_ff @(posedge clk) begin
		if (wea) begin
			mem[wr_addr] <= wr_data;
		end
		if (rd_en) begin
			bias_out <= shifted;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) bias_valid <= 1'b0;
		else     bias_valid <= rd_en;
	end

endmodule

// ==== source/ddr_mux.sv ====
`timescale 1ns/1ps

module ddr_mux (
	input  hwcnn_cmd_pkg::src_t      sel,

	// Shared DDR read side
	output logic                     ddr_conf,
	output hwcnn_cmd_pkg::ddr_cmd_t  ddr_cmd,
	input  logic                     ddr_fifo_empty,
	output logic                     ddr_fifo_req,

	input  logic                     bias_ddr_conf,
	input  hwcnn_cmd_pkg::ddr_cmd_t  bias_ddr_cmd,
	output logic                     bias_ddr_fifo_empty,
	input  logic                     bias_ddr_fifo_req,

	input  logic                     weight_ddr_conf,
	input  hwcnn_cmd_pkg::ddr_cmd_t  weight_ddr_cmd,
	output logic                     weight_ddr_fifo_empty,
	input  logic                     weight_ddr_fifo_req
);

	logic use_weight;

	assign use_weight = (sel == hwcnn_cmd_pkg::SRC_WEIGHT);

	assign ddr_conf = use_weight ? weight_ddr_conf : bias_ddr_conf;
	assign ddr_cmd = use_weight ? weight_ddr_cmd : bias_ddr_cmd;
	assign ddr_fifo_req = use_weight ? weight_ddr_fifo_req : bias_ddr_fifo_req;

	// Unselected side sees a FIFO that is always empty
	assign bias_ddr_fifo_empty = use_weight ? 1'b1 : ddr_fifo_empty;
	assign weight_ddr_fifo_empty = use_weight ? ddr_fifo_empty : 1'b1;

endmodule

// ==== source/fifo_fetch.sv ====
`timescale 1ns/1ps

`include "hwcnn_defines.svh"

module fifo_fetch #(
	parameter type payload_t = logic [`HW_DDR_DATA_LEN-1:0],
	parameter int  ADDR_LEN  = `HW_ADDR_LEN_WB
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         conf,
	input  hwcnn_cmd_pkg::fetch_conf_t   conf_data,
	output logic                         ddr_conf,
	output hwcnn_cmd_pkg::ddr_cmd_t      ddr_cmd,
	input  logic                         ddr_fifo_empty,
	output logic                         ddr_fifo_req,
	input  logic [`HW_DDR_DATA_LEN-1:0]  ddr_fifo_data,
	output logic                         buf_wea,
	output logic [ADDR_LEN-1:0]          buf_addr,
	output payload_t                     buf_data,
	output logic                         idle
);

	localparam int BEAT_SHIFT = $clog2(`HW_DDR_DATA_LEN / 8); // Bytes per beat

	hwcnn_cmd_pkg::fetch_conf_t cfg;
	logic [`HW_SINGLE_LEN-1:0]  req_cnt;
	logic [`HW_SINGLE_LEN-1:0]  wr_cnt;
	logic                       start;
	logic                       done;

	assign start = conf && idle;
	assign done = (buf_wea && (wr_cnt + 1'b1 == cfg.count)) ||
		(ddr_conf && (cfg.count == '0));

	assign ddr_cmd = '{ddr_addr: cfg.ddr_addr, len: cfg.count << BEAT_SHIFT};

	// Pop only once the read command is out and beats remain
	assign ddr_fifo_req = !idle && !ddr_conf && !ddr_fifo_empty && (req_cnt != cfg.count);

	// Popped beat is on the bus one cycle after req
	assign buf_data = payload_t'(ddr_fifo_data);
	assign buf_addr = ADDR_LEN'(cfg.buf_addr + wr_cnt);

	always_ff @(posedge clk) begin
		if (rst) begin
			idle <= 1'b1;
			ddr_conf <= 1'b0;
			buf_wea <= 1'b0;
			req_cnt <= '0;
			wr_cnt <= '0;
		end else begin
			ddr_conf <= start;
			buf_wea <= ddr_fifo_req;
			if (start) begin
				idle <= 1'b0;
				req_cnt <= '0;
				wr_cnt <= '0;
			end else if (!idle) begin
				if (ddr_fifo_req) begin
					req_cnt <= req_cnt + 1'b1;
				end
				if (buf_wea) begin
					wr_cnt <= wr_cnt + 1'b1;
				end
				if (done) begin
					idle <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cfg <= conf_data;
		end
	end

endmodule

// ==== source/load_control.sv ====
`timescale 1ns/1ps

module load_control (
	input  logic                        clk,
	input  logic                        rst,
	input  hwcnn_cmd_pkg::inst_t        instruct,
	input  logic                        inst_empty,
	output logic                        inst_req,
	output logic                        bias_conf,
	output logic                        weight_conf,
	output hwcnn_cmd_pkg::fetch_conf_t  conf,
	output hwcnn_cmd_pkg::src_t         sel,
	input  logic                        bias_idle,
	input  logic                        weight_idle,
	output logic                        busy
);

	typedef enum logic [1:0] {
		S_WAIT,
		S_CONF,
		S_LOAD
	} state_t;

	state_t                 state;
	hwcnn_cmd_pkg::opcode_t op;
	logic                   owner_idle;

	// Take the next instruction only with both controllers at rest
	assign inst_req = (state == S_WAIT) && !inst_empty && bias_idle && weight_idle;
	assign busy = (state != S_WAIT);

	assign bias_conf = (state == S_CONF) && (op == hwcnn_cmd_pkg::OP_LOAD_BIAS);
	assign weight_conf = (state == S_CONF) && (op == hwcnn_cmd_pkg::OP_LOAD_WEIGHT);

	assign owner_idle = (sel == hwcnn_cmd_pkg::SRC_WEIGHT) ? weight_idle : bias_idle;

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_WAIT;
			op <= hwcnn_cmd_pkg::OP_NOP;
			sel <= hwcnn_cmd_pkg::SRC_BIAS;
		end else begin
			case (state)
				S_WAIT: begin
					if (inst_req) begin
						op <= instruct.op;
						case (instruct.op)
							hwcnn_cmd_pkg::OP_LOAD_BIAS: begin
								sel <= hwcnn_cmd_pkg::SRC_BIAS;
								state <= S_CONF;
							end
							hwcnn_cmd_pkg::OP_LOAD_WEIGHT: begin
								sel <= hwcnn_cmd_pkg::SRC_WEIGHT;
								state <= S_CONF;
							end
							default: state <= S_WAIT; // NOP, nothing to launch
						endcase
					end
				end
				S_CONF: state <= S_LOAD;
				S_LOAD: begin
					if (owner_idle) begin
						state <= S_WAIT;
					end
				end
				default: state <= S_WAIT;
			endcase
		end
	end

	// Fetch parameters of the accepted instruction
	always_ff @(posedge clk) begin
		if (inst_req) begin
			conf <= '{ddr_addr: instruct.ddr_addr,
				count: instruct.count,
				buf_addr: instruct.buf_addr};
		end
	end

endmodule

// ==== source/hwcnn_buf_pkg.sv ====
`include "hwcnn_defines.svh"

package hwcnn_buf_pkg;

	////////////////////////////////////////////////////////////
	// Bias storage, one 32-bit slot per lane
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [`HW_DDR_DATA_LEN/`HW_BIAS_LANES-`HW_BIAS_LEN-1:0] pad;
		logic signed [`HW_BIAS_LEN-1:0]                        bias;
	} bias_slot_t;

	typedef bias_slot_t [`HW_BIAS_LANES-1:0] bias_word_t;

	typedef logic [`HW_ADDR_LEN_BB-1:0] bias_addr_t;

	// Readout lanes after sign extension and shift
	typedef logic [`HW_BIAS_LANES-1:0][`HW_COM_DATALEN-1:0] bias_out_t;

	////////////////////////////////////////////////////////////
	// Weight storage
	////////////////////////////////////////////////////////////
	typedef logic signed [`HW_WEIGHT_LANES-1:0][`HW_DDR_DATA_LEN/`HW_WEIGHT_LANES-1:0]
		weight_word_t;

	typedef logic [`HW_ADDR_LEN_WB-1:0] weight_addr_t;

endpackage

// ==== source/hwcnn_cmd_pkg.sv ====
`include "hwcnn_defines.svh"

package hwcnn_cmd_pkg;

	typedef enum logic [1:0] {
		OP_NOP         = 2'd0,
		OP_LOAD_BIAS   = 2'd1,
		OP_LOAD_WEIGHT = 2'd2
	} opcode_t;

	// Buffer address sized for the larger weight buffer
	typedef struct packed {
		opcode_t                    op;
		logic [`HW_DDR_ADDR_LEN-1:0] ddr_addr;
		logic [`HW_SINGLE_LEN-1:0]   count;
		logic [`HW_ADDR_LEN_WB-1:0]  buf_addr;
	} inst_t;

	typedef struct packed {
		logic [`HW_DDR_ADDR_LEN-1:0] ddr_addr;
		logic [`HW_SINGLE_LEN-1:0]   len; // In bytes
	} ddr_cmd_t;

	typedef struct packed {
		logic [`HW_DDR_ADDR_LEN-1:0] ddr_addr;
		logic [`HW_SINGLE_LEN-1:0]   count; // In words
		logic [`HW_ADDR_LEN_WB-1:0]  buf_addr;
	} fetch_conf_t;

	typedef enum logic {
		SRC_BIAS   = 1'b0,
		SRC_WEIGHT = 1'b1
	} src_t;

endpackage

// ==== source/hwcnn_defines.svh ====
`ifndef HWCNN_DEFINES_SVH
`define HWCNN_DEFINES_SVH

////////////////////////////////////////////////////////////
// DDR side
////////////////////////////////////////////////////////////
`define HW_DDR_DATA_LEN 256
`define HW_DDR_ADDR_LEN 32
`define HW_SINGLE_LEN 24 // Length and count fields

////////////////////////////////////////////////////////////
// Buffers
////////////////////////////////////////////////////////////
`define HW_BIAS_LANES 8
`define HW_BIAS_LEN 20
`define HW_COM_DATALEN 24 // Bias width after readout

`define HW_WEIGHT_LANES 32

`define HW_ADDR_LEN_BB 7
`define HW_ADDR_LEN_WB 8

`define HW_SHIFT_LEN 5

`endif
